// ==== vlog.f ====
hw/aluPkg.sv
hw/microcodePkg.sv
hw/controlStore.sv
hw/microSequencer.sv
hw/dataPath.sv
hw/microProcessor.sv
sim/microProcessor_asserts.sv
sim/microProcessorTb.sv

// ==== Bender.yml ====
package:
  name: microprocessor

sources:
  # Packages first, microcodePkg uses aluPkg
  - files:
      - hw/aluPkg.sv
      - hw/microcodePkg.sv
      - hw/controlStore.sv
      - hw/microSequencer.sv
      - hw/dataPath.sv
      - hw/microProcessor.sv

  - target: simulation
    files:
      - sim/microProcessor_asserts.sv
      - sim/microProcessorTb.sv

// ==== sim/microProcessorTb.sv ====
/*
 * Testbench for the microprogrammed processor: ADD, SUBTRACT, MULTIPLY
 * and undefined opcodes with LFSR operands, checked by bound assertions
 */
`timescale 1ns/100ps

module microProcessorTb;

        localparam int         dataWidth = 8;
        localparam logic [3:0] OP_ADD    = 4'h3;
        localparam logic [3:0] OP_SUB    = 4'h7;
        localparam logic [3:0] OP_MUL    = 4'hC;

        logic                 clock;
        logic                 reset;
        logic [3:0]           opcode;
        logic [dataWidth-1:0] operandA;
        logic [dataWidth-1:0] operandB;
        logic                 go;
        logic [dataWidth-1:0] result;
        logic                 done;

        logic [31:0] lfsrState;
        logic [31:0] randomA;
        logic [31:0] randomB;
        logic [3:0]  undefinedOps [4] = '{4'h0, 4'h5, 4'h9, 4'hF};
        int          testCount;
        int          failedTests;
        int          n;

        microProcessor #(.dataWidth(dataWidth)) DUT (
                .clock    (clock),
                .reset    (reset),
                .opcode   (opcode),
                .operandA (operandA),
                .operandB (operandB),
                .go       (go),
                .result   (result),
                .done     (done)
        );

        always #5 clock = ~clock;                       // 10 ns period

        function automatic int assertionErrors();
                return DUT.protocolChecks.errorCount;
        endfunction

        function automatic string opcodeName(input logic [3:0] op);
                case (op)
                OP_ADD:  return "ADD";
                OP_SUB:  return "SUB";
                OP_MUL:  return "MUL";
                default: return $sformatf("UNDEF %0h", op);
                endcase
        endfunction

        // Galois LFSR, one step per bit
        task automatic drawBits(input int count, output logic [31:0] value);
                int i;
                value = '0;
                for (i = 0; i < count; i++) begin
                        value     = {value[30:0], lfsrState[0]};
                        lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
                end
        endtask

        task automatic abortRun(input string reason);
                $display("ERROR at %0t: %s", $time, reason);
                $display("Simulation finished: FAIL");
                $finish;
        endtask

        task automatic waitDone(input logic level, input int limit);
                int cycles;
                cycles = 0;
                while (done !== level) begin
                        @(posedge clock);
                        cycles++;
                        if (cycles > limit) begin
                                abortRun($sformatf("done never reached %0b", level));
                        end
                end
        endtask

        // Idle means the zero flash, then all ones twice
        task automatic waitIdle(input int limit);
                int   cycles;
                int   onesRun;
                logic sawFlash;
                cycles   = 0;
                onesRun  = 0;
                sawFlash = 1'b0;
                while (!(sawFlash && onesRun >= 2)) begin
                        @(posedge clock);
                        cycles++;
                        if (result == '0) begin
                                sawFlash = 1'b1;
                                onesRun  = 0;
                        end else if (result == '1 && !done) begin
                                onesRun++;
                        end else begin
                                onesRun = 0;
                        end
                        if (cycles > limit) begin
                                abortRun("processor did not return to the idle loop");
                        end
                end
        endtask

        task automatic reportTest(input string name, input int errorsBefore);
                testCount++;
                if (assertionErrors() == errorsBefore) begin
                        $display("test %0d %s: ok", testCount, name);
                end else begin
                        failedTests++;
                        $display("test %0d %s: failed", testCount, name);
                end
        endtask

        task automatic runOperation(input logic [3:0] op, input logic [dataWidth-1:0] a,
                                    input logic [dataWidth-1:0] b);
                int errorsBefore;
                errorsBefore = assertionErrors();
                opcode   <= op;                         // Stable until done
                operandA <= a;
                operandB <= b;
                go       <= 1'b1;
                if (op == OP_ADD || op == OP_SUB || op == OP_MUL) begin
                        waitDone(1'b1, 120);
                        repeat (3) @(posedge clock);    // Hold past done
                end else begin
                        repeat (12) @(posedge clock);   // Several dispatch laps
                end
                go <= 1'b0;
                waitDone(1'b0, 8);
                waitIdle(40);
                reportTest($sformatf("%s a=%02h b=%02h", opcodeName(op), a, b), errorsBefore);
        endtask

        initial begin
                clock       = 1'b0;
                reset       = 1'b1;
                opcode      = '0;
                operandA    = '0;
                operandB    = '0;
                go          = 1'b0;
                lfsrState   = 32'hfae8_c069;
                testCount   = 0;
                failedTests = 0;
                repeat (10) @(posedge clock);
                reset <= 1'b0;
                waitIdle(20);
                reportTest("reset", 0);
                for (n = 0; n < 6; n++) begin
                        drawBits(dataWidth, randomA);
                        drawBits(dataWidth, randomB);
                        runOperation(OP_ADD, randomA[dataWidth-1:0], randomB[dataWidth-1:0]);
                        drawBits(dataWidth, randomA);
                        drawBits(dataWidth, randomB);
                        runOperation(OP_SUB, randomA[dataWidth-1:0], randomB[dataWidth-1:0]);
                end
                drawBits(dataWidth, randomA);
                runOperation(OP_MUL, randomA[dataWidth-1:0], '0);       // Skips the loop
                for (n = 0; n < 6; n++) begin
                        drawBits(dataWidth, randomA);
                        drawBits(4, randomB);                   // Bounds multiply latency
                        runOperation(OP_MUL, randomA[dataWidth-1:0], randomB[dataWidth-1:0]);
                end
                for (n = 0; n < 4; n++) begin
                        drawBits(dataWidth, randomA);
                        drawBits(dataWidth, randomB);
                        runOperation(undefinedOps[n], randomA[dataWidth-1:0],
                                     randomB[dataWidth-1:0]);
                end
                repeat (4) @(posedge clock);
                $display("%0d tests, %0d failed, %0d assertion errors",
                         testCount, failedTests, assertionErrors());
                if (failedTests == 0 && assertionErrors() == 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

endmodule

// ==== sim/microProcessor_asserts.sv ====
/*
 * Bound checks for the processor: results while done is high,
 * ADD/SUBTRACT latency and the go/done level handshake
 */
`timescale 1ns/100ps

module microProcessorAsserts #(
        parameter int dataWidth = 8
) (
        input logic                 clock,
        input logic                 reset,
        input logic [3:0]           opcode,
        input logic [dataWidth-1:0] operandA,
        input logic [dataWidth-1:0] operandB,
        input logic                 go,
        input logic [dataWidth-1:0] result,
        input logic                 done
);

        localparam logic [3:0] OP_ADD = 4'h3;
        localparam logic [3:0] OP_SUB = 4'h7;
        localparam logic [3:0] OP_MUL = 4'hC;

        int                   errorCount = 0;   // Read by the testbench
        logic                 goSeen;           // go one cycle ago
        logic [3:0]           runOpcode;        // Copy taken when a run starts
        logic [dataWidth-1:0] runA;
        logic [dataWidth-1:0] runB;
        logic [dataWidth-1:0] expected;

        function automatic logic kept(input logic [3:0] op);
                return (op == OP_ADD) || (op == OP_SUB) || (op == OP_MUL);
        endfunction

        // Reference arithmetic, wraps at dataWidth
        always_comb begin
                case (runOpcode)
                OP_ADD:  expected = runA + runB;
                OP_SUB:  expected = runA - runB;
                default: expected = runA * runB;
                endcase
        end

        always_ff @(posedge clock) begin
                if (reset) begin
                        goSeen    <= 1'b0;
                        runOpcode <= '0;
                        runA      <= '0;
                        runB      <= '0;
                end else begin
                        goSeen <= go;
                        if (go && !goSeen && !done) begin       // New run
                                runOpcode <= opcode;
                                runA      <= operandA;
                                runB      <= operandB;
                        end
                end
        end

        assert property (@(posedge clock) $fell(reset) |-> !done ##[1:4] (result == '1))
        else begin
                errorCount++;
                $error("result not all ones or done high after reset");
        end

        assert property (@(posedge clock) disable iff (reset)
                $rose(go) && !done && (opcode == OP_ADD || opcode == OP_SUB) |-> ##[3:4] done)
        else begin
                errorCount++;
                $error("done late for ADD or SUBTRACT");
        end

        assert property (@(posedge clock) disable iff (reset) done |-> kept(runOpcode))
        else begin
                errorCount++;
                $error("done raised for undefined opcode %0h", $sampled(runOpcode));
        end

        assert property (@(posedge clock) disable iff (reset) done |-> (result == expected))
        else begin
                errorCount++;
                $error("CHECK FAILED t=%0t result: got %0h expected %0h",
                       $time, $sampled(result), $sampled(expected));
        end

        assert property (@(posedge clock) disable iff (reset) done && go |=> done)
        else begin
                errorCount++;
                $error("done dropped while go still held");
        end

        assert property (@(posedge clock) disable iff (reset) done && !go |=> !done)
        else begin
                errorCount++;
                $error("done did not fall one cycle after go fell");
        end

        assert property (@(posedge clock) disable iff (reset)
                $fell(done) |-> ##[1:3] (result == '1))
        else begin
                errorCount++;
                $error("result not back to all ones after done fell");
        end

        assert property (@(posedge clock) disable iff (reset)
                $fell(go) && !kept(runOpcode) |-> ##[1:6] (result == '1))
        else begin
                errorCount++;
                $error("result not all ones after undefined opcode released");
        end

endmodule

bind microProcessor microProcessorAsserts #(.dataWidth(dataWidth)) protocolChecks (
        .clock    (clock),
        .reset    (reset),
        .opcode   (opcode),
        .operandA (operandA),
        .operandB (operandB),
        .go       (go),
        .result   (result),
        .done     (done)
);

// ==== hw/microProcessor.sv ====
/*
 * Microprogrammed arithmetic processor top: sequencer, control store
 * and datapath wired together
 */
`timescale 1ns/100ps

module microProcessor import microcodePkg::*; #(
        parameter int dataWidth = 8
) (
        input  logic                 clock,
        input  logic                 reset,
        input  logic [3:0]           opcode,
        input  logic [dataWidth-1:0] operandA,
        input  logic [dataWidth-1:0] operandB,
        input  logic                 go,        // Held until done
        output logic [dataWidth-1:0] result,
        output logic                 done
);

        logic [7:0] microAddress;               // Micro PC
        microWordT  microWord;                  // Current ROM word
        logic       zero;                       // ALU zero, combinational
        logic       loadInputs;                 // Dispatch strobe

        microSequencer sequencer (
                .clock        (clock),
                .reset        (reset),
                .microWord    (microWord),
                .zero         (zero),
                .go           (go),
                .opcode       (opcode),
                .microAddress (microAddress),
                .loadInputs   (loadInputs),
                .done         (done)
        );

        controlStore store (
                .microAddress (microAddress),
                .microWord    (microWord)
        );

        dataPath #(.dataWidth(dataWidth)) dataPathUnit (
                .clock      (clock),
                .reset      (reset),
                .microWord  (microWord),
                .loadInputs (loadInputs),
                .operandA   (operandA),
                .operandB   (operandB),
                .zero       (zero),
                .result     (result)
        );

endmodule

// ==== hw/dataPath.sv ====
/*
 * Datapath: operand latches, temporaries TA and TB, ALU with source
 * muxes, output register F and zero detect
 */
`timescale 1ns/100ps

module dataPath import microcodePkg::*, aluPkg::*; #(
        parameter int dataWidth = 8
) (
        input  logic                 clock,
        input  logic                 reset,
        input  microWordT            microWord,
        input  logic                 loadInputs,
        input  logic [dataWidth-1:0] operandA,
        input  logic [dataWidth-1:0] operandB,
        output logic                 zero,      // ALU output all zeros
        output logic [dataWidth-1:0] result     // Register F
);

        logic [dataWidth-1:0] inputA;           // Latched operands
        logic [dataWidth-1:0] inputB;
        logic [dataWidth-1:0] tempA;
        logic [dataWidth-1:0] tempB;
        logic [dataWidth-1:0] aluA;
        logic [dataWidth-1:0] aluB;
        logic [dataWidth-1:0] aluOut;
        logic [dataWidth-1:0] carryExt;
        logic                 writeF;
        logic                 writeTA;
        logic                 writeTB;

        // Source muxes
        assign aluA = (microWord.aSource == SRC_INPUT) ? inputA : tempA;
        assign aluB = (microWord.bSource == SRC_INPUT) ? inputB : tempB;

        assign carryExt = dataWidth'(microWord.carryIn);

        // ALU, all arithmetic wraps at dataWidth
        always_comb begin
                case (microWord.aluFunc)
                ALU_A_PLUS_B:  aluOut = aluA + aluB + carryExt;
                ALU_A_MINUS_B: aluOut = aluA + ~aluB + carryExt;   // Needs carry in for A-B
                ALU_A_MINUS_1: aluOut = aluA + {dataWidth{1'b1}} + carryExt;
                ALU_PASS_B:    aluOut = aluB;
                ALU_ZERO:      aluOut = '0;
                ALU_ONES:      aluOut = '1;
                default:       aluOut = '1;             // Unused codes read as ones
                endcase
        end

        assign zero = (aluOut == '0);

        // Destination decode
        assign writeF  = (microWord.aluDest == DEST_F);
        assign writeTA = (microWord.aluDest == DEST_TA) || (microWord.aluDest == DEST_TA_TB);
        assign writeTB = (microWord.aluDest == DEST_TB) || (microWord.aluDest == DEST_TA_TB);

        always_ff @(posedge clock) begin
                if (reset) begin
                        inputA <= '0;
                        inputB <= '0;
                end else if (loadInputs) begin
                        inputA <= operandA;             // Taken at dispatch
                        inputB <= operandB;
                end
        end

        always_ff @(posedge clock) begin
                if (reset) begin
                        tempA  <= '0;
                        tempB  <= '0;
                        result <= '0;
                end else begin
                        if (writeTA) begin
                                tempA <= aluOut;        // Multiply counter
                        end
                        if (writeTB) begin
                                tempB <= aluOut;        // Running sum
                        end
                        if (writeF) begin
                                result <= aluOut;
                        end
                end
        end

endmodule

// ==== hw/microSequencer.sv ====
/*
 * Micro sequencer: micro program counter, next-address selection
 * from the branch operation, and the done flag
 */
`timescale 1ns/100ps

module microSequencer import microcodePkg::*; (
        input  logic       clock,
        input  logic       reset,
        input  microWordT  microWord,
        input  logic       zero,                // From datapath, same cycle
        input  logic       go,
        input  logic [3:0] opcode,
        output logic [7:0] microAddress,
        output logic       loadInputs,          // Latch operands in datapath
        output logic       done
);

        logic [7:0] stepAddress;
        logic [7:0] nextMicroAddress;
        logic       takeJump;

        // Fall-through address, holds when counting is off
        assign stepAddress = microWord.countEnable ? microAddress + 8'd1 : microAddress;

        // Opcode dispatch doubles as the operand load strobe
        assign loadInputs = (microWord.branchOp == BR_OPCODE);

        always_comb begin
                case (microWord.branchOp)
                BR_ZERO:         takeJump = zero;
                BR_NOT_ZERO:     takeJump = !zero;
                BR_WAIT_GO:      takeJump = !go;        // Stay in idle
                BR_WAIT_RELEASE: takeJump = go;         // Stay while held
                BR_BRANCH:       takeJump = 1'b1;
                default:         takeJump = 1'b0;       // Count and dispatch
                endcase
        end

        always_comb begin
                if (loadInputs) begin
                        nextMicroAddress = {opcode, ENTRY_NIBBLE};     // Routine entry
                end else if (takeJump) begin
                        nextMicroAddress = microWord.nextAddress;
                end else begin
                        nextMicroAddress = stepAddress;
                end
        end

        always_ff @(posedge clock) begin
                if (reset) begin
                        microAddress <= RESET_ADDRESS;
                        done         <= 1'b0;
                end else begin
                        microAddress <= nextMicroAddress;
                        // Registered off the wait word, so done lags entry by one
                        // cycle and drops on the edge after go falls
                        done <= (microWord.branchOp == BR_WAIT_RELEASE) && go;
                end
        end

endmodule

// ==== hw/controlStore.sv ====
/*
 * Control store: combinational 256 x 24 microcode ROM holding the
 * reset, idle, ADD, SUBTRACT and MULTIPLY microroutines
 */
`timescale 1ns/100ps

module controlStore import microcodePkg::*, aluPkg::*; (
        input  logic [7:0] microAddress,
        output microWordT  microWord
);

        // Quiet word, each entry overrides what it needs
        localparam microWordT BASE_WORD = '{
                aluDest:     DEST_NONE,
                carryIn:     1'b0,
                aluFunc:     ALU_ONES,
                bSource:     SRC_INPUT,
                aSource:     SRC_INPUT,
                branchOp:    BR_COUNT,
                countEnable: 1'b1,
                nextAddress: 8'h00
        };

        always_comb begin
                microWord = BASE_WORD;
                case (microAddress)
                8'h00: begin                                    // Reset, flash ones
                        microWord.aluDest     = DEST_F;
                        microWord.branchOp    = BR_BRANCH;
                        microWord.nextAddress = FLASH_ADDRESS;
                end
                8'h0C: begin                                    // Flash zero
                        microWord.aluDest     = DEST_F;
                        microWord.aluFunc     = ALU_ZERO;
                end
                8'h0D: begin                                    // Idle, output ones
                        microWord.aluDest     = DEST_F;
                        microWord.branchOp    = BR_WAIT_GO;
                        microWord.nextAddress = IDLE_ADDRESS;   // Loop until go
                end
                8'h0E: begin                                    // Dispatch on opcode
                        microWord.aluDest     = DEST_F;
                        microWord.branchOp    = BR_OPCODE;      // Latches the operands too
                end

                // ADD
                8'h31: begin
                        microWord.aluDest     = DEST_F;
                        microWord.aluFunc     = ALU_A_PLUS_B;   // Sum to output
                end
                8'h32: begin                                    // Hold result
                        microWord.branchOp    = BR_WAIT_RELEASE;
                        microWord.nextAddress = 8'h32;
                end
                8'h33: begin                                    // Zero flash, back to idle
                        microWord.aluDest     = DEST_F;
                        microWord.aluFunc     = ALU_ZERO;
                        microWord.branchOp    = BR_BRANCH;
                        microWord.nextAddress = IDLE_ADDRESS;
                end

                // SUBTRACT
                8'h71: begin
                        microWord.aluDest     = DEST_F;
                        microWord.carryIn     = 1'b1;           // Completes two's complement
                        microWord.aluFunc     = ALU_A_MINUS_B;
                end
                8'h72: begin                                    // Hold result
                        microWord.branchOp    = BR_WAIT_RELEASE;
                        microWord.nextAddress = 8'h72;
                end
                8'h73: begin                                    // Zero flash, back to idle
                        microWord.aluDest     = DEST_F;
                        microWord.aluFunc     = ALU_ZERO;
                        microWord.branchOp    = BR_BRANCH;
                        microWord.nextAddress = IDLE_ADDRESS;
                end

                // MULTIPLY by repeated addition, TA counts and TB sums
                8'hC1: begin
                        microWord.aluDest     = DEST_TA_TB;     // Clear both temps
                        microWord.aluFunc     = ALU_ZERO;
                end
                8'hC2: begin
                        microWord.aluDest     = DEST_TB;        // Clear sum
                        microWord.aluFunc     = ALU_ZERO;
                        microWord.bSource     = SRC_TEMP;
                        microWord.aSource     = SRC_TEMP;
                end
                8'hC3: begin
                        microWord.aluDest     = DEST_TA;        // TA gets operand B
                        microWord.aluFunc     = ALU_PASS_B;
                        microWord.aSource     = SRC_TEMP;
                        microWord.branchOp    = BR_ZERO;        // B of zero skips the loop
                        microWord.nextAddress = 8'hC6;
                end
                8'hC4: begin
                        microWord.aluDest     = DEST_TB;        // TB += A
                        microWord.aluFunc     = ALU_A_PLUS_B;
                        microWord.bSource     = SRC_TEMP;
                end
                8'hC5: begin
                        microWord.aluDest     = DEST_TA;        // Count down
                        microWord.aluFunc     = ALU_A_MINUS_1;
                        microWord.bSource     = SRC_TEMP;
                        microWord.aSource     = SRC_TEMP;
                        microWord.branchOp    = BR_NOT_ZERO;
                        microWord.nextAddress = 8'hC4;
                end
                8'hC6: begin
                        microWord.aluDest     = DEST_F;         // Show product
                        microWord.aluFunc     = ALU_PASS_B;
                        microWord.bSource     = SRC_TEMP;
                        microWord.aSource     = SRC_TEMP;
                        microWord.branchOp    = BR_WAIT_RELEASE;
                        microWord.nextAddress = 8'hC6;
                end
                8'hC7: begin                                    // Zero flash, back to idle
                        microWord.aluDest     = DEST_F;
                        microWord.aluFunc     = ALU_ZERO;
                        microWord.branchOp    = BR_BRANCH;
                        microWord.nextAddress = IDLE_ADDRESS;
                end

                default: begin                                  // Undefined, restart
                        microWord.aluDest     = DEST_F;
                        microWord.branchOp    = BR_BRANCH;
                        microWord.nextAddress = RESET_ADDRESS;
                end
                endcase
        end

endmodule

// ==== hw/microcodePkg.sv ====
/*
 * Microcode definitions: 24-bit microword layout, branch operations
 * and the fixed microaddresses known to the sequencer
 */
package microcodePkg;

        // Source of the next microaddress
        typedef enum logic [3:0] {
                BR_ZERO         = 4'b0000,      // Jump when ALU output is zero
                BR_WAIT_GO      = 4'b0100,      // Loop while go low
                BR_COUNT        = 4'b0110,      // Plain step
                BR_NOT_ZERO     = 4'b1000,      // Jump when ALU output nonzero
                BR_WAIT_RELEASE = 4'b1100,      // Loop while go held
                BR_BRANCH       = 4'b1110,      // Unconditional jump
                BR_OPCODE       = 4'b1111       // Dispatch, also loads inputs
        } branchOpT;

        // Field order matches the ROM bit layout, MSB first
        typedef struct packed {
                aluPkg::aluDestT   aluDest;     // [23:21]
                logic              carryIn;     // [20]
                aluPkg::aluFuncT   aluFunc;     // [19:15]
                aluPkg::aluSourceT bSource;     // [14]
                aluPkg::aluSourceT aSource;     // [13]
                branchOpT          branchOp;    // [12:9]
                logic              countEnable; // [8] step when not jumping
                logic [7:0]        nextAddress; // [7:0]
        } microWordT;

        // Fixed points of the microprogram
        localparam logic [7:0] RESET_ADDRESS = 8'h00;  // Entry after reset
        localparam logic [7:0] FLASH_ADDRESS = 8'h0C;  // Zero flash before idle
        localparam logic [7:0] IDLE_ADDRESS  = 8'h0D;  // Wait for go

        // Every opcode routine starts at {opcode, 1}
        localparam logic [3:0] ENTRY_NIBBLE  = 4'h1;

endpackage

// ==== hw/aluPkg.sv ====
/*
 * ALU definitions for the microprogrammed processor: function codes,
 * register destinations and operand sources
 */
package aluPkg;

        // Function codes as carried in the microword
        typedef enum logic [4:0] {
                ALU_A_MINUS_B = 5'b00110,       // A plus not B plus carry
                ALU_A_PLUS_B  = 5'b01001,       // A plus B plus carry
                ALU_A_MINUS_1 = 5'b01111,       // A minus one plus carry
                ALU_ZERO      = 5'b10011,       // Constant zero
                ALU_PASS_B    = 5'b11010,       // B straight through
                ALU_ONES      = 5'b11100        // Constant all ones
        } aluFuncT;

        // Registers written at the end of the microcycle
        typedef enum logic [2:0] {
                DEST_F     = 3'b011,            // Output register
                DEST_TA_TB = 3'b100,            // Both temporaries
                DEST_TB    = 3'b101,            // Temporary B
                DEST_TA    = 3'b110,            // Temporary A
                DEST_NONE  = 3'b111             // No write
        } aluDestT;

        // Operand select, one per ALU input
        typedef enum logic {
                SRC_TEMP  = 1'b0,               // TA or TB
                SRC_INPUT = 1'b1                // Latched operand
        } aluSourceT;

endpackage
